// File: src/izh_params.svh
`ifndef IZH_PARAMS_SVH
`define IZH_PARAMS_SVH

// datapath geometry
// every neuron value is signed Q16.16
`define IZH_WIDTH      32
`define IZH_FRAC_BITS  16

// stage strobes, go through the spike/reset output stage
`define IZH_STAGES     4

// membrane equation constants, all in Q16.16
// 0.04 * 65536 = 2621.44, rounded down
`define IZH_K_0P04     (32'sd2621)
`define IZH_K_5        (32'sd327680)
`define IZH_K_140      (32'sd9175040)

// recovery equation constants
// a = 0.02, 1310.72 rounded up
`define IZH_K_A        (32'sd1311)
// b = 0.2, 13107.2 rounded down
`define IZH_K_B        (32'sd13107)

// after-spike reset values
// c = -65 mV
`define IZH_K_C        (-32'sd4259840)
// d = 2, added to the incoming u
`define IZH_K_D        (32'sd131072)

// spike threshold, 30 mV
`define IZH_V_PEAK     (32'sd1966080)

`endif

// File: src/izhPkg.sv
`default_nettype none

`include "izh_params.svh"

package izhPkg;

  // membrane potential, recovery and current all share this format
  typedef logic signed [`IZH_WIDTH-1:0] neuronVal;

  // untruncated product of two neuron values
  typedef logic signed [2*`IZH_WIDTH-1:0] wideProduct;

  // one load strobe per pipeline stage
  typedef logic [`IZH_STAGES-1:0] stageMask;

  // Q16.16 multiply
  // both operands get sign extended to the product width first,
  // the arithmetic shift floors toward minus infinity
  function automatic neuronVal qMul(input neuronVal a, input neuronVal b);
    wideProduct full;
    full = a * b;
    full = full >>> `IZH_FRAC_BITS;
    // keep low word, wraps like every other add in the datapath
    return neuronVal'(full[`IZH_WIDTH-1:0]);
  endfunction

endpackage

`default_nettype wire

// File: src/stageTimeline.sv
`default_nettype none

`include "izh_params.svh"

module stageTimeline (
  input  logic             clk,
  input  logic             reset,
  input  logic             go,
  output izhPkg::stageMask stageEn,
  output logic             ready
);

  // goDelay[k] is go seen k cycles ago
  // bit 0 is not stored, it is the live go input
  logic [`IZH_STAGES:1] goDelay;

  // plain shift register, one bit per stage
  // several neurons can be in flight, so no counter here
  always_ff @(posedge clk) begin
    if (reset) begin
      goDelay <= '0;
    end else begin
      // shift up, new go enters at the bottom
      goDelay <= {goDelay[`IZH_STAGES-1:1], go};
    end
  end

  // stage 1 loads straight on go
  // later stages load on its delayed copies
  assign stageEn = {goDelay[`IZH_STAGES-1:1], go};

  // result registers loaded one edge earlier, so ready lines up with them
  assign ready = goDelay[`IZH_STAGES];

endmodule

`default_nettype wire

// File: src/membraneUpdate.sv
`default_nettype none

`include "izh_params.svh"

module membraneUpdate (
  input  logic             clk,
  input  logic             reset,
  input  izhPkg::stageMask stageEn,
  input  izhPkg::neuronVal vIn,
  input  izhPkg::neuronVal uIn,
  input  izhPkg::neuronVal iIn,
  output izhPkg::neuronVal vNext
);

  import izhPkg::*;

  // vNext = 0.04*v^2 + 5*v + 140 - u + i
  // split so each stage has at most one multiply on its path

  // stage 1 results
  neuronVal vSquare;
  neuronVal vTimes5;
  // 140 - u + i, the part that does not depend on v
  neuronVal driveTerm;

  // stage 2 results
  neuronVal quadTerm;
  neuronVal linearSum;

  // stage 1, loads with go from the top-level inputs
  always_ff @(posedge clk) begin
    if (reset) begin
      vSquare   <= '0;
      vTimes5   <= '0;
      driveTerm <= '0;
    end else if (stageEn[0]) begin
      vSquare   <= qMul(vIn, vIn);
      // exact, 5.0 has no fraction bits to lose
      vTimes5   <= qMul(vIn, `IZH_K_5);
      driveTerm <= `IZH_K_140 - uIn + iIn;
    end
  end

  // stage 2
  // scale the square, fold the linear part into the drive
  always_ff @(posedge clk) begin
    if (reset) begin
      quadTerm  <= '0;
      linearSum <= '0;
    end else if (stageEn[1]) begin
      // 0.04 is inexact in Q16.16, truncation happens here
      quadTerm  <= qMul(vSquare, `IZH_K_0P04);
      linearSum <= vTimes5 + driveTerm;
    end
  end

  // stage 3, final add
  // holds until the next neuron reaches this stage
  always_ff @(posedge clk) begin
    if (reset) begin
      vNext <= '0;
    end else if (stageEn[2]) begin
      vNext <= quadTerm + linearSum;
    end
  end

endmodule

`default_nettype wire

// File: src/recoveryUpdate.sv
`default_nettype none

`include "izh_params.svh"

module recoveryUpdate (
  input  logic             clk,
  input  logic             reset,
  input  izhPkg::stageMask stageEn,
  input  izhPkg::neuronVal vIn,
  input  izhPkg::neuronVal uIn,
  output izhPkg::neuronVal uNext,
  output izhPkg::neuronVal uSpike
);

  import izhPkg::*;

  // uNext  = u + a*(b*v - u)
  // uSpike = u + d, used by spikeReset when the neuron fires
  // both are built from the u presented with go

  // stage 1
  neuronVal bTimesV;
  neuronVal uStage1;
  neuronVal uPlusD1;

  // stage 2
  neuronVal bvMinusU;
  neuronVal uStage2;
  neuronVal uPlusD2;

  // stage 1, capture inputs and start b*v
  always_ff @(posedge clk) begin
    if (reset) begin
      bTimesV <= '0;
      uStage1 <= '0;
      uPlusD1 <= '0;
    end else if (stageEn[0]) begin
      bTimesV <= qMul(vIn, `IZH_K_B);
      uStage1 <= uIn;
      // d path is ready early and just rides along
      uPlusD1 <= uIn + `IZH_K_D;
    end
  end

  // stage 2, difference term
  // u and u + d are carried forward with it
  always_ff @(posedge clk) begin
    if (reset) begin
      bvMinusU <= '0;
      uStage2  <= '0;
      uPlusD2  <= '0;
    end else if (stageEn[1]) begin
      bvMinusU <= bTimesV - uStage1;
      uStage2  <= uStage1;
      uPlusD2  <= uPlusD1;
    end
  end

  // stage 3
  // scale by a and add the original u back
  always_ff @(posedge clk) begin
    if (reset) begin
      uNext  <= '0;
      uSpike <= '0;
    end else if (stageEn[2]) begin
      uNext  <= uStage2 + qMul(`IZH_K_A, bvMinusU);
      uSpike <= uPlusD2;
    end
  end

endmodule

`default_nettype wire

// File: src/spikeReset.sv
`default_nettype none

`include "izh_params.svh"

module spikeReset (
  input  logic             clk,
  input  logic             reset,
  input  logic             load,
  input  izhPkg::neuronVal vNext,
  input  izhPkg::neuronVal uNext,
  input  izhPkg::neuronVal uSpike,
  output izhPkg::neuronVal vOut,
  output izhPkg::neuronVal uOut,
  output logic             spike
);

  import izhPkg::*;

  // threshold test on the freshly computed potential
  // signed compare, both sides are neuronVal
  logic aboveThreshold;

  assign aboveThreshold = (vNext >= neuronVal'(`IZH_V_PEAK));

  // output registers
  // they keep the last result until the next load
  always_ff @(posedge clk) begin
    if (reset) begin
      vOut  <= '0;
      uOut  <= '0;
      spike <= 1'b0;
    end else if (load) begin
      if (aboveThreshold) begin
        // fired, reset to c and bump recovery by d
        vOut  <= neuronVal'(`IZH_K_C);
        uOut  <= uSpike;
        spike <= 1'b1;
      end else begin
        // no spike, pass the Euler step through
        vOut  <= vNext;
        uOut  <= uNext;
        spike <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/izhikevichStep.sv
`default_nettype none

`include "izh_params.svh"

module izhikevichStep (
  input  logic             clk,
  input  logic             reset,
  input  logic             go,
  input  izhPkg::neuronVal vIn,
  input  izhPkg::neuronVal uIn,
  input  izhPkg::neuronVal iIn,
  output izhPkg::neuronVal vOut,
  output izhPkg::neuronVal uOut,
  output logic             spike,
  output logic             ready
);

  import izhPkg::*;

  // per-stage load strobes from the timeline
  stageMask stageEn;

  // stage 3 results handed to the output stage
  neuronVal vNext;
  neuronVal uNext;
  neuronVal uSpike;

  // control, go delayed once per stage
  stageTimeline i_stageTimeline (
    .clk     (clk),
    .reset   (reset),
    .go      (go),
    .stageEn (stageEn),
    .ready   (ready)
  );

  // potential path, stages 1..3
  membraneUpdate i_membraneUpdate (
    .clk     (clk),
    .reset   (reset),
    .stageEn (stageEn),
    .vIn     (vIn),
    .uIn     (uIn),
    .iIn     (iIn),
    .vNext   (vNext)
  );

  // recovery path runs alongside, same strobes
  recoveryUpdate i_recoveryUpdate (
    .clk     (clk),
    .reset   (reset),
    .stageEn (stageEn),
    .vIn     (vIn),
    .uIn     (uIn),
    .uNext   (uNext),
    .uSpike  (uSpike)
  );

  // stage 4, threshold and final registers
  spikeReset i_spikeReset (
    .clk    (clk),
    .reset  (reset),
    .load   (stageEn[`IZH_STAGES-1]),
    .vNext  (vNext),
    .uNext  (uNext),
    .uSpike (uSpike),
    .vOut   (vOut),
    .uOut   (uOut),
    .spike  (spike)
  );

endmodule

`default_nettype wire

// File: verif/izhModel.svh
`ifndef IZH_MODEL_SVH
`define IZH_MODEL_SVH

// expected results for one Euler step of the Izhikevich neuron
// everything is signed Q16.16, adds and subtracts wrap at 32 bits

// Q16.16 product
// full 64-bit product, floor shift by the fraction bits, keep the low word
function automatic neuronVal fixMul(input neuronVal x, input neuronVal y);
  logic signed [2*`IZH_WIDTH-1:0] xWide;
  logic signed [2*`IZH_WIDTH-1:0] yWide;
  logic signed [2*`IZH_WIDTH-1:0] prod;
  xWide = x;
  yWide = y;
  prod = xWide * yWide;
  prod = prod >>> `IZH_FRAC_BITS;
  return prod[`IZH_WIDTH-1:0];
endfunction

// vNext = 0.04*v^2 + 5*v + 140 - u + i
// the square is truncated before scaling by 0.04
function automatic neuronVal membraneNext(input neuronVal v, input neuronVal u,
                                          input neuronVal i);
  neuronVal square;
  square = fixMul(v, v);
  return fixMul(square, `IZH_K_0P04) + fixMul(v, `IZH_K_5) + `IZH_K_140 - u + i;
endfunction

// uNext = u + a*(b*v - u)
function automatic neuronVal recoveryNext(input neuronVal v, input neuronVal u);
  return u + fixMul(`IZH_K_A, fixMul(`IZH_K_B, v) - u);
endfunction

// full step with the spike rule applied
// at or above the peak: v goes to c, u becomes input u plus d
task automatic predictStep(input neuronVal v, input neuronVal u, input neuronVal i,
                           output neuronVal vExp, output neuronVal uExp,
                           output logic spikeExp);
  neuronVal vNew;
  vNew = membraneNext(v, u, i);
  if (vNew >= `IZH_V_PEAK) begin
    vExp     = `IZH_K_C;
    uExp     = u + `IZH_K_D;
    spikeExp = 1'b1;
  end else begin
    vExp     = vNew;
    uExp     = recoveryNext(v, u);
    spikeExp = 1'b0;
  end
endtask

`endif

// File: verif/izhikevichStepTb.sv
`default_nettype none

`include "izh_params.svh"

module izhikevichStepTb;

  timeunit 1ns;
  timeprecision 1ps;

  import izhPkg::*;

  `include "izhModel.svh"

  // inputs change this long after the rising edge
  localparam int DRIVE_DELAY = 2;
  // room for about 300 steps with a 4-cycle drain each plus idle gaps
  localparam int MAX_CYCLES = 3000;
  // cycles allowed for the pipe to empty before giving up
  localparam int DRAIN_LIMIT = 20;

  logic     clk;
  logic     reset;
  logic     go;
  neuronVal vIn;
  neuronVal uIn;
  neuronVal iIn;
  neuronVal vOut;
  neuronVal uOut;
  logic     spike;
  logic     ready;

  // expected results with one entry per go and the oldest first
  neuronVal expV[$];
  neuronVal expU[$];
  logic     expS[$];

  string  testName = "init";
  integer seed;
  int     cycleCount = 0;
  int     checks = 0;
  int     errors = 0;
  int     readyCount = 0;
  int     lastReadyCycle = 0;
  int     lastIssueCycle = 0;

  izhikevichStep i_izhikevichStep (
    .clk   (clk),
    .reset (reset),
    .go    (go),
    .vIn   (vIn),
    .uIn   (uIn),
    .iIn   (iIn),
    .vOut  (vOut),
    .uOut  (uOut),
    .spike (spike),
    .ready (ready)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // cycle counter doubles as the watchdog
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= MAX_CYCLES) begin
      $display("Error: run hit the cycle limit of %0d during %s", MAX_CYCLES, testName);
      $display("checks %0d errors %0d", checks, errors + 1);
      $display("Regression failed");
      $finish;
    end
  end

  // whole numbers to Q16.16
  function automatic neuronVal toFixed(input int whole);
    return neuronVal'(whole * 65536);
  endfunction

  task automatic checkValue(input string what, input neuronVal want, input neuronVal got);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("Mismatch %s %s expected %h actual %h", testName, what, want, got);
    end
  endtask

  task automatic checkBit(input string what, input logic want, input logic got);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("Mismatch %s %s expected %b actual %b", testName, what, want, got);
    end
  endtask

  // outputs are stable at the falling edge
  // one result is popped per ready
  always @(negedge clk) begin
    if (ready === 1'b1) begin
      readyCount++;
      lastReadyCycle = cycleCount;
      checks++;
      assert (expV.size() > 0) else begin
        errors++;
        $display("Error: %s got a ready pulse with no step in flight", testName);
      end
      if (expV.size() > 0) begin
        checkValue("vOut", expV.pop_front(), vOut);
        checkValue("uOut", expU.pop_front(), uOut);
        checkBit("spike", expS.pop_front(), spike);
      end
    end
  end

  task automatic nextSlot();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // one go pulse
  // expected result is queued before the DUT samples it
  task automatic sendStep(input neuronVal v, input neuronVal u, input neuronVal i);
    neuronVal wantV;
    neuronVal wantU;
    logic     wantS;
    predictStep(v, u, i, wantV, wantU, wantS);
    expV.push_back(wantV);
    expU.push_back(wantU);
    expS.push_back(wantS);
    go  = 1'b1;
    vIn = v;
    uIn = u;
    iIn = i;
    lastIssueCycle = cycleCount;
    nextSlot();
    go = 1'b0;
  endtask

  // wait a bounded time for every queued step to come back
  task automatic drainPipe();
    int waited;
    waited = 0;
    while (expV.size() > 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    checks++;
    assert (expV.size() == 0) else begin
      errors++;
      $display("Error: %s timed out waiting for ready, %0d steps outstanding",
               testName, expV.size());
    end
    nextSlot();
  endtask

  task automatic drawRange(input int lo, input int hi, output neuronVal val);
    int unsigned span;
    int unsigned r;
    span = hi - lo + 1;
    r = $random(seed);
    val = lo + int'(r % span);
  endtask

  // resting neuron
  // also pins the 4-cycle latency
  task automatic testResting();
    testName = "testResting";
    sendStep(toFixed(-65), toFixed(-13), toFixed(0));
    drainPipe();
    checks++;
    assert (lastReadyCycle - lastIssueCycle == 4) else begin
      errors++;
      $display("Error: %s ready came %0d cycles after go instead of 4",
               testName, lastReadyCycle - lastIssueCycle);
    end
    checkBit("spike held", 1'b0, spike);
  endtask

  task automatic testSpike();
    testName = "testSpike";
    // vNext far above the peak
    sendStep(toFixed(35), toFixed(-10), toFixed(10));
    drainPipe();
    checkValue("vOut held", toFixed(-65), vOut);
    checkValue("uOut held", toFixed(-8), uOut);
    checkBit("spike held", 1'b1, spike);
    // v = 0 leaves 140 - u + i which lands exactly on 30
    sendStep(toFixed(0), toFixed(110), toFixed(0));
    drainPipe();
    checkValue("vOut at peak", toFixed(-65), vOut);
    checkValue("uOut at peak", toFixed(112), uOut);
    checkBit("spike at peak", 1'b1, spike);
    // one LSB below the peak must not fire
    sendStep(toFixed(0), toFixed(110), neuronVal'(-1));
    drainPipe();
    checkBit("spike below peak", 1'b0, spike);
  endtask

  task automatic testBackToBack();
    int firstIssue;
    int startCount;
    testName = "testBackToBack";
    startCount = readyCount;
    firstIssue = cycleCount;
    for (int k = 0; k < 10; k++) begin
      sendStep(toFixed(-70 + 9 * k), toFixed(-15 + 3 * k), toFixed(2 * k));
    end
    drainPipe();
    // ten pulses ending 13 cycles after the first go means no gaps
    checks++;
    assert (readyCount - startCount == 10 && lastReadyCycle - firstIssue == 13) else begin
      errors++;
      $display("Error: %s burst gave %0d ready pulses, last one %0d cycles after the first go",
               testName, readyCount - startCount, lastReadyCycle - firstIssue);
    end
  endtask

  task automatic testReset();
    testName = "testReset";
    for (int k = 0; k < 6; k++) begin
      sendStep(toFixed(-60 + k), toFixed(-12), toFixed(5));
    end
    // go stays high through reset and must be ignored
    reset = 1'b1;
    go    = 1'b1;
    vIn   = toFixed(20);
    nextSlot();
    // steps still in the pipe were flushed by that edge
    expV.delete();
    expU.delete();
    expS.delete();
    nextSlot();
    nextSlot();
    reset = 1'b0;
    go    = 1'b0;
    repeat (6) begin
      @(negedge clk);
      checks++;
      assert (ready === 1'b0) else begin
        errors++;
        $display("Error: %s saw ready after reset with nothing issued", testName);
      end
    end
    checkValue("vOut after reset", '0, vOut);
    checkValue("uOut after reset", '0, uOut);
    checkBit("spike after reset", 1'b0, spike);
    nextSlot();
  endtask

  task automatic testRandom();
    neuronVal v;
    neuronVal u;
    neuronVal i;
    int       gap;
    testName = "testRandom";
    for (int n = 0; n < 200; n++) begin
      drawRange(toFixed(-80), toFixed(40), v);
      drawRange(toFixed(-20), toFixed(20), u);
      drawRange(toFixed(0), toFixed(20), i);
      sendStep(v, u, i);
      // 0 to 3 idle cycles between steps
      gap = $random(seed) & 3;
      repeat (gap) nextSlot();
    end
    drainPipe();
  endtask

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    go    = 1'b0;
    vIn   = '0;
    uIn   = '0;
    iIn   = '0;
    seed  = 32'h99dba3c2;
    repeat (3) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;

    testResting();
    testSpike();
    testBackToBack();
    testReset();
    testRandom();

    testName = "end of run";
    checks++;
    assert (expV.size() == 0) else begin
      errors++;
      $display("Error: %0d expected results were never returned", expV.size());
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+src
+incdir+verif
src/izhPkg.sv
src/stageTimeline.sv
src/membraneUpdate.sv
src/recoveryUpdate.sv
src/spikeReset.sv
src/izhikevichStep.sv
verif/izhikevichStepTb.sv
